// ==== hw/mem_sched_consts.svh ====
// Memory issue constants
// Sizes shared by the load/store queue, the scheduler and the data ports

`ifndef MEM_SCHED_CONSTS_SVH
`define MEM_SCHED_CONSTS_SVH

// ====================
// Queue geometry
// ====================

// Number of entries in the load/store queue
`define LSQ_ENTRIES 16

// Entries the scheduler examines, counted from the queue head
// This has to stay at or below the queue depth
`define WINDOW_SIZE 8

// Number of data cache ports fed per cycle
`define NDATA_PORTS 2

// ====================
// Addressing
// ====================

// Width of a physical byte address
`define PADR_WIDTH 32

// Low address bits that select a byte inside one 16-byte line
`define LINE_SHIFT 4

`endif

// ==== hw/addr_pkg.sv ====
// Address types for the memory issue path
// Physical byte addresses and the line tags used for conflict checks

`include "mem_sched_consts.svh"

package addr_pkg;

	// Byte address as the data cache sees it
	typedef logic [`PADR_WIDTH-1:0] physical_address_t;

	// Address with the offset inside a line stripped off
	// Two operations touch the same line when their tags are equal
	typedef logic [`PADR_WIDTH-`LINE_SHIFT-1:0] line_tag_t;

endpackage

// ==== hw/lsq_pkg.sv ====
// Load/store queue types
// Entry index, per-entry bitmask and the life cycle of one entry

`include "mem_sched_consts.svh"

package lsq_pkg;

	// Position of an entry inside the circular queue
	typedef logic [$clog2(`LSQ_ENTRIES)-1:0] lsq_ndx_t;

	// One bit per queue entry, bit n belongs to entry n
	typedef logic [`LSQ_ENTRIES-1:0] lsq_bitmask_t;

	// ====================
	// Entry life cycle
	// ====================

	// An entry is allocated without an address and waits for address generation
	// Once the address is known it is ready and may be picked by the scheduler
	// A picked entry is issued until the memory side reports it done
	// Done entries leave the queue in order from the head
	typedef enum logic [2:0] {
		free,
		wait_agen,
		ready,
		issued,
		done
	} lsq_state_t;

endpackage

// ==== hw/lsq_store.sv ====
// Load/store queue storage
// Allocates entries in program order, records addresses from address
// generation, tracks each entry's state and retires done entries from
// the head. A flush empties the whole queue.

`timescale 1ns/1ns

`include "mem_sched_consts.svh"

module lsq_store (
	input  logic clk,
	input  logic reset,
	input  logic alloc,
	input  logic alloc_store,
	input  logic alloc_spec,
	input  logic agen_valid,
	input  lsq_pkg::lsq_ndx_t agen_ndx,
	input  addr_pkg::physical_address_t agen_addr,
	input  logic resolve,
	input  logic flush,
	input  logic done_valid,
	input  lsq_pkg::lsq_ndx_t done_ndx,
	input  lsq_pkg::lsq_bitmask_t issue_mask,
	output lsq_pkg::lsq_state_t [`LSQ_ENTRIES-1:0] entry_state,
	output lsq_pkg::lsq_bitmask_t entry_store,
	output lsq_pkg::lsq_bitmask_t entry_spec,
	output addr_pkg::physical_address_t [`LSQ_ENTRIES-1:0] entry_addr,
	output addr_pkg::line_tag_t [`LSQ_ENTRIES-1:0] entry_line,
	output lsq_pkg::lsq_ndx_t head,
	output logic full
);

	import addr_pkg::*;
	import lsq_pkg::*;

	// Next entry to be allocated
	lsq_ndx_t tail;
	// Entries between head and tail, one bit wider than an index so 16 fits
	logic [$clog2(`LSQ_ENTRIES):0] used_count;
	logic alloc_ok;
	logic retire_ok;

	// Allocation is dropped while every entry is in use
	assign alloc_ok = alloc && !full;

	// Only the head can leave, and only once the memory side has finished it
	assign retire_ok = (entry_state[head] == done);

	assign full = (used_count == `LSQ_ENTRIES);

	// ====================
	// Entry state
	// ====================

	// Later assignments win when two events hit the same entry in one cycle
	// Flush beats everything else
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			for (int i = 0; i < `LSQ_ENTRIES; i++) begin
				entry_state[i] <= free;
			end
			entry_store <= '0;
			entry_spec <= '0;
			head <= '0;
			tail <= '0;
			used_count <= '0;
		end else begin
			// Picks registered by the scheduler last cycle are now on the ports
			for (int i = 0; i < `LSQ_ENTRIES; i++) begin
				if (issue_mask[i] && entry_state[i] == ready) begin
					entry_state[i] <= issued;
				end
			end

			// The address arrives once, for an entry still waiting on it
			if (agen_valid && entry_state[agen_ndx] == wait_agen) begin
				entry_state[agen_ndx] <= ready;
			end

			// Completion may be reported for any entry that is in use
			if (done_valid && entry_state[done_ndx] != free) begin
				entry_state[done_ndx] <= done;
			end

			// In-order retirement, one entry per cycle at most
			if (retire_ok) begin
				entry_state[head] <= free;
				head <= head + 1'b1;
			end

			// The branch in front of all speculative entries has resolved
			if (resolve) begin
				entry_spec <= '0;
			end

			// New entry goes in at the tail
			// Its own spec bit wins over a resolve in the same cycle
			if (alloc_ok) begin
				entry_state[tail] <= wait_agen;
				entry_store[tail] <= alloc_store;
				entry_spec[tail] <= alloc_spec;
				tail <= tail + 1'b1;
			end

			case ({alloc_ok, retire_ok})
				2'b10: used_count <= used_count + 1'b1;
				2'b01: used_count <= used_count - 1'b1;
				default: used_count <= used_count;
			endcase
		end
	end

	// ====================
	// Entry payload
	// ====================

	// Address storage, only meaningful while the entry is past wait_agen
	always_ff @(posedge clk) begin
		if (agen_valid) begin
			entry_addr[agen_ndx] <= agen_addr;
		end
	end

	// Line tag of each entry for the scheduler's overlap check
	always_comb begin
		for (int i = 0; i < `LSQ_ENTRIES; i++) begin
			entry_line[i] = line_tag_t'(entry_addr[i] >> `LINE_SHIFT);
		end
	end

endmodule

// ==== hw/mem_sched.sv ====
// Memory operation scheduler
// Walks the oldest entries of the load/store queue from the head and
// picks up to two of them per cycle for the data ports, keeping loads
// and stores in a safe order. The picks are registered.

`timescale 1ns/1ns

`include "mem_sched_consts.svh"

module mem_sched (
	input  logic clk,
	input  logic reset,
	input  lsq_pkg::lsq_ndx_t head,
	input  lsq_pkg::lsq_state_t [`LSQ_ENTRIES-1:0] entry_state,
	input  lsq_pkg::lsq_bitmask_t entry_store,
	input  lsq_pkg::lsq_bitmask_t entry_spec,
	input  addr_pkg::line_tag_t [`LSQ_ENTRIES-1:0] entry_line,
	input  logic flush,
	output lsq_pkg::lsq_bitmask_t issue_mask,
	output lsq_pkg::lsq_ndx_t ndx0,
	output lsq_pkg::lsq_ndx_t ndx1,
	output logic ndx0v,
	output logic ndx1v
);

	import addr_pkg::*;
	import lsq_pkg::*;

	// Queue entry held by each window slot, slot 0 is the head
	lsq_ndx_t [`WINDOW_SIZE-1:0] slot_ndx;
	// Entries that are in use
	lsq_bitmask_t entry_valid;
	// Entries that could go to a port this cycle if ordering allows
	lsq_bitmask_t entry_cand;

	// Selection result ahead of the register
	lsq_bitmask_t pick_mask;
	lsq_ndx_t pick0;
	lsq_ndx_t pick1;
	logic pick0v;
	logic pick1v;

	// Scratch values for the window walk
	lsq_ndx_t cur_ndx;
	lsq_ndx_t old_ndx;
	line_tag_t cur_line;
	logic pick_ok;
	logic store_taken;
	logic [1:0] taken;

	// Slot positions wrap around the end of the queue
	always_comb begin
		for (int w = 0; w < `WINDOW_SIZE; w++) begin
			slot_ndx[w] = head + lsq_ndx_t'(w);
		end
	end

	// A pick still sitting in issue_mask is not taken twice
	// Stores wait until no unresolved branch is in front of them
	always_comb begin
		for (int i = 0; i < `LSQ_ENTRIES; i++) begin
			entry_valid[i] = (entry_state[i] != free);
			entry_cand[i] = (entry_state[i] == ready) && !issue_mask[i]
				&& !(entry_store[i] && entry_spec[i]);
		end
	end

	// ====================
	// Window walk
	// ====================

	always_comb begin
		pick_mask = '0;
		pick0 = '0;
		pick1 = '0;
		pick0v = 1'b0;
		pick1v = 1'b0;
		taken = 2'd0;
		store_taken = 1'b0;
		cur_ndx = '0;
		old_ndx = '0;
		cur_line = '0;
		pick_ok = 1'b0;
		for (int w = 0; w < `WINDOW_SIZE; w++) begin
			cur_ndx = slot_ndx[w];
			cur_line = entry_line[cur_ndx];
			pick_ok = entry_cand[cur_ndx] && (taken < `NDATA_PORTS);
			// The head has nothing older to wait for
			if (w != 0) begin
				for (int p = 0; p < w; p++) begin
					old_ndx = slot_ndx[p];
					if (entry_valid[old_ndx]) begin
						// An older operation without an address might overlap
						if (entry_state[old_ndx] == wait_agen) begin
							pick_ok = 1'b0;
						end
						// Same line as anything older still in the queue
						if (entry_line[old_ndx] == cur_line) begin
							pick_ok = 1'b0;
						end
					end
				end
				// Only one store goes out per cycle
				if (store_taken && entry_store[cur_ndx]) begin
					pick_ok = 1'b0;
				end
			end
			if (pick_ok) begin
				pick_mask[cur_ndx] = 1'b1;
				// The walk is oldest first, so slot 0 always gets the older pick
				if (taken == 2'd0) begin
					pick0 = cur_ndx;
					pick0v = 1'b1;
				end else begin
					pick1 = cur_ndx;
					pick1v = 1'b1;
				end
				if (entry_store[cur_ndx]) begin
					store_taken = 1'b1;
				end
				taken = taken + 2'd1;
			end
		end
	end

	// Picks made before a flush belong to squashed work and are dropped
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			issue_mask <= '0;
			ndx0 <= '0;
			ndx1 <= '0;
			ndx0v <= 1'b0;
			ndx1v <= 1'b0;
		end else begin
			issue_mask <= pick_mask;
			ndx0 <= pick0;
			ndx1 <= pick1;
			ndx0v <= pick0v;
			ndx1v <= pick1v;
		end
	end

endmodule

// ==== hw/data_port_issue.sv ====
// Data port issue stage
// Looks up the address and kind of each scheduled entry and drives
// them onto the two data cache ports for one cycle

`timescale 1ns/1ns

`include "mem_sched_consts.svh"

module data_port_issue (
	input  logic clk,
	input  logic reset,
	input  logic flush,
	input  lsq_pkg::lsq_ndx_t ndx0,
	input  lsq_pkg::lsq_ndx_t ndx1,
	input  logic ndx0v,
	input  logic ndx1v,
	input  addr_pkg::physical_address_t [`LSQ_ENTRIES-1:0] entry_addr,
	input  lsq_pkg::lsq_bitmask_t entry_store,
	output logic port0_valid,
	output logic port1_valid,
	output lsq_pkg::lsq_ndx_t port0_ndx,
	output lsq_pkg::lsq_ndx_t port1_ndx,
	output addr_pkg::physical_address_t port0_addr,
	output addr_pkg::physical_address_t port1_addr,
	output logic port0_store,
	output logic port1_store
);

	import addr_pkg::*;
	import lsq_pkg::*;

	// Scheduler slots gathered so both ports share one datapath
	lsq_ndx_t [`NDATA_PORTS-1:0] sel_ndx;
	logic [`NDATA_PORTS-1:0] sel_v;
	physical_address_t [`NDATA_PORTS-1:0] sel_addr;
	logic [`NDATA_PORTS-1:0] sel_store;

	// Port registers
	logic [`NDATA_PORTS-1:0] out_valid;
	lsq_ndx_t [`NDATA_PORTS-1:0] out_ndx;
	physical_address_t [`NDATA_PORTS-1:0] out_addr;
	logic [`NDATA_PORTS-1:0] out_store;

	assign sel_ndx[0] = ndx0;
	assign sel_ndx[1] = ndx1;
	assign sel_v = {ndx1v, ndx0v};

	// Read the queue payload of each picked entry
	always_comb begin
		for (int p = 0; p < `NDATA_PORTS; p++) begin
			sel_addr[p] = entry_addr[sel_ndx[p]];
			sel_store[p] = entry_store[sel_ndx[p]];
		end
	end

	// A flush also kills picks that were about to reach the ports
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			out_valid <= '0;
		end else begin
			out_valid <= sel_v;
		end
	end

	always_ff @(posedge clk) begin
		out_ndx <= sel_ndx;
		out_addr <= sel_addr;
		out_store <= sel_store;
	end

	assign port0_valid = out_valid[0];
	assign port0_ndx = out_ndx[0];
	assign port0_addr = out_addr[0];
	assign port0_store = out_store[0];
	assign port1_valid = out_valid[1];
	assign port1_ndx = out_ndx[1];
	assign port1_addr = out_addr[1];
	assign port1_store = out_store[1];

endmodule

// ==== hw/mem_issue_top.sv ====
// Memory issue subsystem
// Load/store queue, scheduler and data port stage joined together

`timescale 1ns/1ns

`include "mem_sched_consts.svh"

module mem_issue_top (
	input  logic clk,
	input  logic reset,
	input  logic alloc,
	input  logic alloc_store,
	input  logic alloc_spec,
	input  logic agen_valid,
	input  lsq_pkg::lsq_ndx_t agen_ndx,
	input  addr_pkg::physical_address_t agen_addr,
	input  logic resolve,
	input  logic flush,
	input  logic done_valid,
	input  lsq_pkg::lsq_ndx_t done_ndx,
	output logic full,
	output logic port0_valid,
	output lsq_pkg::lsq_ndx_t port0_ndx,
	output addr_pkg::physical_address_t port0_addr,
	output logic port0_store,
	output logic port1_valid,
	output lsq_pkg::lsq_ndx_t port1_ndx,
	output addr_pkg::physical_address_t port1_addr,
	output logic port1_store
);

	import addr_pkg::*;
	import lsq_pkg::*;

	// Queue contents seen by the scheduler and the port stage
	lsq_state_t [`LSQ_ENTRIES-1:0] entry_state;
	lsq_bitmask_t entry_store;
	lsq_bitmask_t entry_spec;
	physical_address_t [`LSQ_ENTRIES-1:0] entry_addr;
	line_tag_t [`LSQ_ENTRIES-1:0] entry_line;
	lsq_ndx_t head;

	// Registered picks
	lsq_bitmask_t issue_mask;
	lsq_ndx_t ndx0;
	lsq_ndx_t ndx1;
	logic ndx0v;
	logic ndx1v;

	lsq_store i_store (
		.clk(clk), .reset(reset),
		.alloc(alloc), .alloc_store(alloc_store), .alloc_spec(alloc_spec),
		.agen_valid(agen_valid), .agen_ndx(agen_ndx), .agen_addr(agen_addr),
		.resolve(resolve), .flush(flush),
		.done_valid(done_valid), .done_ndx(done_ndx),
		.issue_mask(issue_mask),
		.entry_state(entry_state), .entry_store(entry_store), .entry_spec(entry_spec),
		.entry_addr(entry_addr), .entry_line(entry_line),
		.head(head), .full(full)
	);

	mem_sched i_sched (
		.clk(clk), .reset(reset), .head(head),
		.entry_state(entry_state), .entry_store(entry_store), .entry_spec(entry_spec),
		.entry_line(entry_line), .flush(flush),
		.issue_mask(issue_mask),
		.ndx0(ndx0), .ndx1(ndx1), .ndx0v(ndx0v), .ndx1v(ndx1v)
	);

	data_port_issue i_port (
		.clk(clk), .reset(reset), .flush(flush),
		.ndx0(ndx0), .ndx1(ndx1), .ndx0v(ndx0v), .ndx1v(ndx1v),
		.entry_addr(entry_addr), .entry_store(entry_store),
		.port0_valid(port0_valid), .port1_valid(port1_valid),
		.port0_ndx(port0_ndx), .port1_ndx(port1_ndx),
		.port0_addr(port0_addr), .port1_addr(port1_addr),
		.port0_store(port0_store), .port1_store(port1_store)
	);

endmodule

// ==== tests/tb_mem_issue.sv ====
// Memory issue subsystem testbench
// Directed tests for issue timing, pairing, ordering rules, line conflicts,
// store rules, a full queue and flush recovery

`timescale 1ns/1ns

`include "mem_sched_consts.svh"

module tb_mem_issue;

	import addr_pkg::*;
	import lsq_pkg::*;

	logic clk;
	logic reset;
	logic alloc;
	logic alloc_store;
	logic alloc_spec;
	logic agen_valid;
	lsq_ndx_t agen_ndx;
	physical_address_t agen_addr;
	logic resolve;
	logic flush;
	logic done_valid;
	lsq_ndx_t done_ndx;
	logic full;
	logic port0_valid;
	lsq_ndx_t port0_ndx;
	physical_address_t port0_addr;
	logic port0_store;
	logic port1_valid;
	lsq_ndx_t port1_ndx;
	physical_address_t port1_addr;
	logic port1_store;

	integer seed;
	int errors;
	int checks;
	// Queue fill level and tail as the testbench counts them from allocations
	int in_use;
	lsq_ndx_t tail_ndx;

	mem_issue_top i_dut (
		.clk(clk), .reset(reset),
		.alloc(alloc), .alloc_store(alloc_store), .alloc_spec(alloc_spec),
		.agen_valid(agen_valid), .agen_ndx(agen_ndx), .agen_addr(agen_addr),
		.resolve(resolve), .flush(flush),
		.done_valid(done_valid), .done_ndx(done_ndx),
		.full(full),
		.port0_valid(port0_valid), .port0_ndx(port0_ndx),
		.port0_addr(port0_addr), .port0_store(port0_store),
		.port1_valid(port1_valid), .port1_ndx(port1_ndx),
		.port1_addr(port1_addr), .port1_store(port1_store)
	);

	// 100 ns clock period
	always #50 clk = ~clk;

	// ====================
	// Helpers
	// ====================

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// Random address whose bits 7:4 pick the line so that different selectors never share one
	task automatic make_addr(input logic [3:0] line_sel, output physical_address_t addr);
		addr = $random(seed);
		addr[7:4] = line_sel;
	endtask

	function automatic logic port_valid(input int port);
		return (port == 0) ? port0_valid : port1_valid;
	endfunction

	// All drive tasks start on a falling edge and return on the next one
	task automatic alloc_op(input logic store, input logic spec, output lsq_ndx_t ndx);
		ndx = tail_ndx;
		alloc = 1'b1;
		alloc_store = store;
		alloc_spec = spec;
		@(negedge clk);
		alloc = 1'b0;
		alloc_store = 1'b0;
		alloc_spec = 1'b0;
		// A full queue drops the request and the tail stays put
		if (in_use < `LSQ_ENTRIES) begin
			tail_ndx = tail_ndx + 1'b1;
			in_use++;
		end
	endtask

	task automatic agen_op(input lsq_ndx_t ndx, input physical_address_t addr);
		agen_valid = 1'b1;
		agen_ndx = ndx;
		agen_addr = addr;
		@(negedge clk);
		agen_valid = 1'b0;
	endtask

	task automatic done_op(input lsq_ndx_t ndx);
		done_valid = 1'b1;
		done_ndx = ndx;
		@(negedge clk);
		done_valid = 1'b0;
	endtask

	task automatic resolve_pulse();
		resolve = 1'b1;
		@(negedge clk);
		resolve = 1'b0;
	endtask

	// Whole-queue flush that sends head and tail back to entry 0
	task automatic clear_queue();
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		tail_ndx = '0;
		in_use = 0;
	endtask

	// Counts the edges until the port shows a valid operation
	task automatic wait_port(input int port, output int edges);
		edges = 0;
		while (!port_valid(port) && edges < 20) begin
			@(negedge clk);
			edges++;
		end
		if (!port_valid(port)) begin
			errors++;
			$display("Timeout: data port %0d never showed a valid operation", port);
		end
	endtask

	task automatic wait_full(input logic value);
		int n;
		n = 0;
		while (full !== value && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (full !== value) begin
			errors++;
			$display("Timeout: the full flag never went to %0d", value);
		end
	endtask

	// Neither port may issue during the given number of cycles
	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			compare("port0_valid while blocked", port0_valid, 1'b0);
			compare("port1_valid while blocked", port1_valid, 1'b0);
		end
	endtask

	task automatic check_port(input int port, input lsq_ndx_t ndx,
			input physical_address_t addr, input logic store);
		if (port == 0) begin
			compare("port0_ndx", port0_ndx, ndx);
			compare("port0_addr", port0_addr, addr);
			compare("port0_store", port0_store, store);
		end else begin
			compare("port1_ndx", port1_ndx, ndx);
			compare("port1_addr", port1_addr, addr);
			compare("port1_store", port1_store, store);
		end
	endtask

	// ====================
	// Tests
	// ====================

	task automatic single_load_test();
		lsq_ndx_t a;
		physical_address_t addr;
		int edges;
		clear_queue();
		make_addr(4'h1, addr);
		alloc_op(1'b0, 1'b0, a);
		agen_op(a, addr);
		wait_port(0, edges);
		// Pick is registered one edge after agen and the port one edge later
		compare("load issue latency", edges, 2);
		check_port(0, a, addr, 1'b0);
		compare("port1_valid for single load", port1_valid, 1'b0);
		@(negedge clk);
		compare("port0_valid one cycle later", port0_valid, 1'b0);
	endtask

	task automatic load_pair_test();
		lsq_ndx_t a;
		lsq_ndx_t b;
		physical_address_t addr_a;
		physical_address_t addr_b;
		int edges;
		clear_queue();
		make_addr(4'h2, addr_a);
		make_addr(4'h3, addr_b);
		alloc_op(1'b0, 1'b0, a);
		alloc_op(1'b0, 1'b0, b);
		// There is a single agen port, so the younger load gets its address first
		// and both become eligible on the edge the older one gets its address
		agen_op(b, addr_b);
		agen_op(a, addr_a);
		wait_port(0, edges);
		compare("pair issue latency", edges, 2);
		check_port(0, a, addr_a, 1'b0);
		compare("port1_valid for pair", port1_valid, 1'b1);
		check_port(1, b, addr_b, 1'b0);
	endtask

	task automatic unknown_addr_test();
		lsq_ndx_t s;
		lsq_ndx_t b;
		physical_address_t addr_s;
		physical_address_t addr_b;
		int edges;
		clear_queue();
		make_addr(4'h4, addr_s);
		make_addr(4'h5, addr_b);
		alloc_op(1'b1, 1'b0, s);
		alloc_op(1'b0, 1'b0, b);
		agen_op(b, addr_b);
		// The older store has no address yet, so the load might overlap it
		expect_quiet(5);
		agen_op(s, addr_s);
		wait_port(0, edges);
		check_port(0, s, addr_s, 1'b1);
		if (port1_valid) begin
			check_port(1, b, addr_b, 1'b0);
		end else begin
			@(negedge clk);
			wait_port(0, edges);
			check_port(0, b, addr_b, 1'b0);
		end
	endtask

	task automatic line_conflict_test();
		lsq_ndx_t a;
		lsq_ndx_t b;
		physical_address_t addr_a;
		physical_address_t addr_b;
		int edges;
		clear_queue();
		make_addr(4'h6, addr_a);
		// Same 16-byte line at another byte offset
		addr_b = {addr_a[31:4], addr_a[3:0] ^ 4'h8};
		alloc_op(1'b0, 1'b0, a);
		alloc_op(1'b0, 1'b0, b);
		agen_op(a, addr_a);
		agen_op(b, addr_b);
		wait_port(0, edges);
		check_port(0, a, addr_a, 1'b0);
		compare("port1_valid with line conflict", port1_valid, 1'b0);
		// The older load stays valid until it is done and retired
		expect_quiet(4);
		done_op(a);
		wait_port(0, edges);
		check_port(0, b, addr_b, 1'b0);
	endtask

	task automatic store_order_test();
		lsq_ndx_t s0;
		lsq_ndx_t s1;
		physical_address_t addr0;
		physical_address_t addr1;
		int edges;
		clear_queue();
		make_addr(4'h7, addr0);
		alloc_op(1'b1, 1'b1, s0);
		agen_op(s0, addr0);
		// Speculative store holds until the branch resolves
		expect_quiet(5);
		resolve_pulse();
		wait_port(0, edges);
		compare("store issue after resolve", edges, 2);
		check_port(0, s0, addr0, 1'b1);

		clear_queue();
		make_addr(4'h8, addr0);
		make_addr(4'h9, addr1);
		alloc_op(1'b1, 1'b0, s0);
		alloc_op(1'b1, 1'b0, s1);
		agen_op(s1, addr1);
		agen_op(s0, addr0);
		wait_port(0, edges);
		check_port(0, s0, addr0, 1'b1);
		compare("port1_valid with two stores", port1_valid, 1'b0);
		@(negedge clk);
		wait_port(0, edges);
		check_port(0, s1, addr1, 1'b1);
		compare("port1_valid for second store", port1_valid, 1'b0);
	endtask

	task automatic full_flush_test();
		lsq_ndx_t n;
		physical_address_t addr;
		int edges;
		clear_queue();
		for (int i = 0; i < `LSQ_ENTRIES; i++) begin
			alloc_op(1'b0, 1'b0, n);
			compare("full while filling", full, (i == `LSQ_ENTRIES - 1));
		end
		// This request must be dropped
		alloc_op(1'b0, 1'b0, n);
		compare("full after dropped alloc", full, 1'b1);

		// Finish the head entry so it retires and frees a slot
		make_addr(4'hA, addr);
		agen_op(4'd0, addr);
		wait_port(0, edges);
		check_port(0, 4'd0, addr, 1'b0);
		done_op(4'd0);
		wait_full(1'b0);
		in_use--;
		alloc_op(1'b0, 1'b0, n);
		compare("full after refill", full, 1'b1);

		// Flush while entry 1's pick sits in the scheduler register
		make_addr(4'hB, addr);
		agen_op(4'd1, addr);
		@(negedge clk);
		clear_queue();
		compare("port0_valid right after flush", port0_valid, 1'b0);
		expect_quiet(5);
		compare("full after flush", full, 1'b0);
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		seed = 86;
		errors = 0;
		checks = 0;
		in_use = 0;
		tail_ndx = '0;
		clk = 1'b0;
		reset = 1'b1;
		alloc = 1'b0;
		alloc_store = 1'b0;
		alloc_spec = 1'b0;
		agen_valid = 1'b0;
		agen_ndx = '0;
		agen_addr = '0;
		resolve = 1'b0;
		flush = 1'b0;
		done_valid = 1'b0;
		done_ndx = '0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		compare("full after reset", full, 1'b0);
		compare("port0_valid after reset", port0_valid, 1'b0);
		compare("port1_valid after reset", port1_valid, 1'b0);

		single_load_test();
		load_pair_test();
		unknown_addr_test();
		line_conflict_test();
		store_order_test();
		full_flush_test();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+hw
hw/addr_pkg.sv
hw/lsq_pkg.sv
hw/lsq_store.sv
hw/mem_sched.sv
hw/data_port_issue.sv
hw/mem_issue_top.sv
tests/tb_mem_issue.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the memory issue testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_mem_issue -f project.f \
	-o tb_mem_issue > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_mem_issue > sim.log 2>&1 || { cat sim.log; echo "Simulation did not finish"; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "Test run failed"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "No result line in sim.log"; exit 1; }
echo "Test run passed"
